//--- rtl/rack_pkg.sv
`default_nettype none

package rack_pkg;

    // one full host word: parameters, rates, currents and counts
    typedef logic [31:0] word_t;

    // one wire-in word from the host side
    typedef logic [15:0] half_t;

    // trigger strobe vector, one bit per loadable parameter
    typedef logic [15:0] trig_t;

    // registered FIFO status pair
    typedef logic [1:0] fifo_flags_t;

    // bit positions inside fifo_flags_t
    localparam int FIFO_AFULL_BIT  = 0;
    localparam int FIFO_AEMPTY_BIT = 1;

    // trigger bit assignment
    localparam int TRIG_GAIN_IA   = 1;
    localparam int TRIG_OFFSET_IA = 3;
    localparam int TRIG_OFFSET_II = 6;
    localparam int TRIG_TICK_DIV  = 7;
    localparam int TRIG_GAIN_II   = 10;

    // reset defaults, offsets in pulses per second
    localparam word_t DEF_OFFSET_IA = 32'd70;
    localparam word_t DEF_OFFSET_II = 32'd50;

    // gains in Q16.16, 1.2 and 2.0
    localparam word_t DEF_GAIN_IA = 32'd78643;
    localparam word_t DEF_GAIN_II = 32'd131072;

    // 381 cycles per tick gives half real-time speed on the rack
    localparam word_t DEF_TICK_DIV = 32'd381;

    // fraction width of the gain words
    localparam int GAIN_FRAC_BITS = 16;

    // rate to neuron current scaling
    localparam int CURRENT_SHIFT = 6;

    // low current bits replaced with pseudo-random dither
    localparam int DITHER_BITS = 11;

    // galois feedback mask for x^32 + x^22 + x^2 + x + 1
    localparam word_t LFSR_TAPS = 32'h8020_0003;

    // per-channel seeds, must differ and be nonzero
    localparam word_t LFSR_SEED_IA = 32'hace1_2f0d;
    localparam word_t LFSR_SEED_II = 32'h5b3c_96e7;

endpackage

`default_nettype wire

//--- rtl/param_decode.sv
`default_nettype none

module param_decode import rack_pkg::*;
(
    input  wire         ep50trig,
    input  wire         reset_global,
    input  wire trig_t  i_trig,
    input  wire half_t  i_wire_hi,
    input  wire half_t  i_wire_lo,
    output word_t       o_offset_ia,
    output word_t       o_offset_ii,
    output word_t       o_gain_ia,
    output word_t       o_gain_ii,
    output word_t       o_tick_div
);

    // joined wire-in pair, hi word on top
    word_t load_word;

    // per-parameter load enables
    logic  load_offset_ia;
    logic  load_offset_ii;
    logic  load_gain_ia;
    logic  load_gain_ii;
    logic  load_tick_div;

    assign load_word = {i_wire_hi, i_wire_lo};

    // unassigned trigger bits simply have no enable
    assign load_offset_ia = i_trig[TRIG_OFFSET_IA];
    assign load_offset_ii = i_trig[TRIG_OFFSET_II];
    assign load_gain_ia   = i_trig[TRIG_GAIN_IA];
    assign load_gain_ii   = i_trig[TRIG_GAIN_II];
    assign load_tick_div  = i_trig[TRIG_TICK_DIV];

    // offsets subtracted from the raw afferent rates
    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            o_offset_ia <= DEF_OFFSET_IA;
            o_offset_ii <= DEF_OFFSET_II;
        end
        else
        begin
            // several strobes in one cycle all load the same word
            if (load_offset_ia)
                o_offset_ia <= load_word;
            if (load_offset_ii)
                o_offset_ii <= load_word;
        end
    end

    // Q16.16 gains
    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            o_gain_ia <= DEF_GAIN_IA;
            o_gain_ii <= DEF_GAIN_II;
        end
        else
        begin
            if (load_gain_ia)
                o_gain_ia <= load_word;
            if (load_gain_ii)
                o_gain_ii <= load_word;
        end
    end

    // millisecond tick period in clock cycles
    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
            o_tick_div <= DEF_TICK_DIV;
        else if (load_tick_div)
            o_tick_div <= load_word;
    end

    // a zero period would stall the monitor tick and the time tag behind it
    a_tick_div_nonzero : assert property (
        @(posedge ep50trig) disable iff (reset_global)
        o_tick_div != '0
    ) else $error("tick divider loaded with zero");

endmodule

`default_nettype wire

//--- rtl/afferent_current.sv
`default_nettype none

module afferent_current import rack_pkg::*;
#(
    parameter word_t LFSR_SEED = LFSR_SEED_IA
)
(
    input  wire         ep50trig,
    input  wire         reset_global,
    input  wire         i_sim_reset,
    input  wire word_t  i_rate,
    input  wire word_t  i_offset,
    input  wire word_t  i_gain,
    output word_t       o_current
);

    // stage 1 result, signed rate minus offset
    word_t diff_q;

    // full signed product, gain taken as unsigned by a zero top bit
    logic signed [64:0] prod;

    // product with the Q16.16 fraction dropped
    logic signed [64:0] prod_int;

    // integer rate scaled up to neuron current
    word_t scaled;

    // dither source
    word_t lfsr_q;
    word_t lfsr_next;

    // stage 1
    always_ff @(posedge ep50trig)
    begin
        diff_q <= word_t'($signed(i_rate) - $signed(i_offset));
    end

    // gain applied to the registered difference
    assign prod = $signed(diff_q) * $signed({1'b0, i_gain});

    // arithmetic shift keeps negative rates negative
    assign prod_int = prod >>> GAIN_FRAC_BITS;

    assign scaled = prod_int[31:0] << CURRENT_SHIFT;

    // right-shifting galois step
    always_comb
    begin
        if (lfsr_q[0])
            lfsr_next = (lfsr_q >> 1) ^ LFSR_TAPS;
        else
            lfsr_next = lfsr_q >> 1;
    end

    // free running, one step per clock
    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
            lfsr_q <= LFSR_SEED;
        else if (i_sim_reset)
            lfsr_q <= LFSR_SEED;
        else
            lfsr_q <= lfsr_next;
    end

    // stage 2
    // upper bits carry the current, low bits are noise so neurons do not phase-lock
    always_ff @(posedge ep50trig)
    begin
        o_current <= {scaled[31:DITHER_BITS], lfsr_q[DITHER_BITS-1:0]};
    end

    // a zero state would lock the generator and freeze the dither
    a_lfsr_nonzero : assert property (
        @(posedge ep50trig) disable iff (reset_global)
        lfsr_q != '0
    ) else $error("dither lfsr reached the all-zero state");

endmodule

`default_nettype wire

//--- rtl/rack_monitor.sv
`default_nettype none

module rack_monitor import rack_pkg::*;
(
    input  wire         ep50trig,
    input  wire         reset_global,
    input  wire         i_sim_reset,
    input  wire word_t  i_tick_div,
    input  wire         i_spike_ia,
    input  wire         i_spike_ii,
    input  wire         i_fifo_almost_full,
    input  wire         i_fifo_almost_empty,
    output logic        o_tick,
    output word_t       o_time_tag,
    output word_t       o_spike_count_ia,
    output word_t       o_spike_count_ii,
    output fifo_flags_t o_fifo_flags
);

    // cycle count inside the current tick period
    word_t div_cnt;

    // last count of the period
    // >= so that a smaller divider loaded mid-period still wraps
    logic  div_wrap;

    assign div_wrap = (div_cnt >= i_tick_div - 32'd1);

    // tick and time tag move on the same edge
    // sim reset leaves both alone
    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            div_cnt    <= '0;
            o_tick     <= 1'b0;
            o_time_tag <= '0;
        end
        else if (div_wrap)
        begin
            div_cnt    <= '0;
            o_tick     <= 1'b1;
            o_time_tag <= o_time_tag + 32'd1;
        end
        else
        begin
            div_cnt <= div_cnt + 32'd1;
            o_tick  <= 1'b0;
        end
    end

    // one count per cycle with the spike input high
    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            o_spike_count_ia <= '0;
            o_spike_count_ii <= '0;
        end
        else if (i_sim_reset)
        begin
            o_spike_count_ia <= '0;
            o_spike_count_ii <= '0;
        end
        else
        begin
            o_spike_count_ia <= o_spike_count_ia + word_t'(i_spike_ia);
            o_spike_count_ii <= o_spike_count_ii + word_t'(i_spike_ii);
        end
    end

    // FIFO status, one register stage
    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
            o_fifo_flags <= '0;
        else
        begin
            o_fifo_flags[FIFO_AFULL_BIT]  <= i_fifo_almost_full;
            o_fifo_flags[FIFO_AEMPTY_BIT] <= i_fifo_almost_empty;
        end
    end

    // with a period above one cycle the tick is a single-cycle pulse
    a_tick_single_cycle : assert property (
        @(posedge ep50trig) disable iff (reset_global)
        (o_tick && (i_tick_div > 32'd1)) |=> (!o_tick || (i_tick_div <= 32'd1))
    ) else $error("tick held high for two cycles");

endmodule

`default_nettype wire

//--- rtl/rack_core.sv
`default_nettype none

module rack_core import rack_pkg::*;
(
    input  wire              ep50trig,
    input  wire              reset_global,
    input  wire              i_sim_reset,
    input  wire trig_t       i_trig,
    input  wire half_t       i_wire_hi,
    input  wire half_t       i_wire_lo,
    input  wire word_t       i_rate_ia,
    input  wire word_t       i_rate_ii,
    input  wire              i_spike_ia,
    input  wire              i_spike_ii,
    input  wire              i_fifo_almost_full,
    input  wire              i_fifo_almost_empty,
    output wire word_t       o_current_ia,
    output wire word_t       o_current_ii,
    output wire              o_tick,
    output wire word_t       o_time_tag,
    output wire word_t       o_spike_count_ia,
    output wire word_t       o_spike_count_ii,
    output wire fifo_flags_t o_fifo_flags
);

    // registered parameters from the trigger bank
    wire word_t offset_ia;
    wire word_t offset_ii;
    wire word_t gain_ia;
    wire word_t gain_ii;
    wire word_t tick_div;

    param_decode u_param_decode (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_trig       (i_trig),
        .i_wire_hi    (i_wire_hi),
        .i_wire_lo    (i_wire_lo),
        .o_offset_ia  (offset_ia),
        .o_offset_ii  (offset_ii),
        .o_gain_ia    (gain_ia),
        .o_gain_ii    (gain_ii),
        .o_tick_div   (tick_div)
    );

    // Ia channel, primary endings
    afferent_current #(.LFSR_SEED(LFSR_SEED_IA)) afferent_ia (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_sim_reset  (i_sim_reset),
        .i_rate       (i_rate_ia),
        .i_offset     (offset_ia),
        .i_gain       (gain_ia),
        .o_current    (o_current_ia)
    );

    // II channel, secondary endings, own seed so the dither is uncorrelated
    afferent_current #(.LFSR_SEED(LFSR_SEED_II)) afferent_ii (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_sim_reset  (i_sim_reset),
        .i_rate       (i_rate_ii),
        .i_offset     (offset_ii),
        .i_gain       (gain_ii),
        .o_current    (o_current_ii)
    );

    rack_monitor u_rack_monitor (
        .ep50trig            (ep50trig),
        .reset_global        (reset_global),
        .i_sim_reset         (i_sim_reset),
        .i_tick_div          (tick_div),
        .i_spike_ia          (i_spike_ia),
        .i_spike_ii          (i_spike_ii),
        .i_fifo_almost_full  (i_fifo_almost_full),
        .i_fifo_almost_empty (i_fifo_almost_empty),
        .o_tick              (o_tick),
        .o_time_tag          (o_time_tag),
        .o_spike_count_ia    (o_spike_count_ia),
        .o_spike_count_ii    (o_spike_count_ii),
        .o_fifo_flags        (o_fifo_flags)
    );

endmodule

`default_nettype wire

//--- verif/tb_rack_core.sv
`default_nettype none

module tb_rack_core import rack_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_HALF     = 10;
    localparam int RESET_CYCLES = 5;
    localparam int DRIVE_DELAY  = 2;
    localparam int MAX_RECORDS  = 64;
    localparam int REC_WORDS    = 5;

    // record opcodes in the stimulus file
    localparam word_t OP_END       = 32'd0;
    localparam word_t OP_TRIG      = 32'd1;
    localparam word_t OP_RATE      = 32'd2;
    localparam word_t OP_SPIKE     = 32'd3;
    localparam word_t OP_TICK      = 32'd4;
    localparam word_t OP_FIFO      = 32'd5;
    localparam word_t OP_SIM_RESET = 32'd6;

    localparam word_t ALL_BITS = '1;
    // only the bits above the dither field are predictable
    localparam word_t CURRENT_MASK = ~((word_t'(1) << DITHER_BITS) - word_t'(1));

    logic        ep50trig;
    logic        reset_global;
    logic        i_sim_reset;
    trig_t       i_trig;
    half_t       i_wire_hi;
    half_t       i_wire_lo;
    word_t       i_rate_ia;
    word_t       i_rate_ii;
    logic        i_spike_ia;
    logic        i_spike_ii;
    logic        i_fifo_almost_full;
    logic        i_fifo_almost_empty;
    wire word_t  o_current_ia;
    wire word_t  o_current_ii;
    wire         o_tick;
    wire word_t  o_time_tag;
    wire word_t  o_spike_count_ia;
    wire word_t  o_spike_count_ii;
    wire fifo_flags_t o_fifo_flags;

    word_t stim_mem [0:MAX_RECORDS*REC_WORDS-1];
    int    limit_cycles = 0;
    int    cycle_count = 0;
    int    cur_record = 0;
    word_t rnd_state = 32'hf7a1;
    // own tally of driven spikes since the last sim reset
    word_t tally_ia = '0;
    word_t tally_ii = '0;
    // flag pair expected on the register until the next edge
    fifo_flags_t flags_prev = '0;

    rack_core dut (
        .ep50trig            (ep50trig),
        .reset_global        (reset_global),
        .i_sim_reset         (i_sim_reset),
        .i_trig              (i_trig),
        .i_wire_hi           (i_wire_hi),
        .i_wire_lo           (i_wire_lo),
        .i_rate_ia           (i_rate_ia),
        .i_rate_ii           (i_rate_ii),
        .i_spike_ia          (i_spike_ia),
        .i_spike_ii          (i_spike_ii),
        .i_fifo_almost_full  (i_fifo_almost_full),
        .i_fifo_almost_empty (i_fifo_almost_empty),
        .o_current_ia        (o_current_ia),
        .o_current_ii        (o_current_ii),
        .o_tick              (o_tick),
        .o_time_tag          (o_time_tag),
        .o_spike_count_ia    (o_spike_count_ia),
        .o_spike_count_ii    (o_spike_count_ii),
        .o_fifo_flags        (o_fifo_flags)
    );

    // 20 ns clock
    always #CLK_HALF ep50trig = ~ep50trig;

    // watchdog on the total cycle budget
    always @(posedge ep50trig)
    begin
        cycle_count <= cycle_count + 1;
        if (limit_cycles != 0 && cycle_count >= limit_cycles)
        begin
            $display("timeout: run went past %0d clock cycles", limit_cycles);
            $display("FAIL: see errors above");
            $fatal(1, "watchdog expired");
        end
    end

    function automatic word_t xorshift32(input word_t x);
        word_t v;
        v = x;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // worst-case cycles one record may take
    function automatic int record_cycles(input word_t op, input word_t a0, input word_t a1);
        int n;
        case (op)
            OP_TRIG:      n = 1;
            OP_RATE:      n = 2;
            OP_SPIKE:     n = int'(a0);
            OP_TICK:      n = (int'(a0) + 1) * int'(a1);
            OP_FIFO:      n = 1;
            OP_SIM_RESET: n = 2;
            default:      n = 1;
        endcase
        return n;
    endfunction

    // advance to just after the next rising edge
    task automatic step_cycle();
        @(posedge ep50trig);
        #DRIVE_DELAY;
    endtask

    task automatic check_word(input word_t actual, input word_t expected,
                              input word_t mask, input string what);
        if ((actual & mask) !== (expected & mask))
        begin
            $display("Fail at %0d ns: record %0d %s got %h expected %h (mask %h)",
                     $time, cur_record, what, actual, expected, mask);
            $display("FAIL: see errors above");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic check_flags(input fifo_flags_t actual, input fifo_flags_t expected,
                               input string what);
        if (actual !== expected)
        begin
            $display("Fail at %0d ns: record %0d %s got %b expected %b",
                     $time, cur_record, what, actual, expected);
            $display("FAIL: see errors above");
            $fatal(1, "flag mismatch");
        end
    endtask

    // one-cycle strobe with both wire words held alongside
    task automatic load_trigger(input word_t mask, input word_t value);
        i_trig    = trig_t'(mask);
        i_wire_hi = value[31:16];
        i_wire_lo = value[15:0];
        step_cycle();
        i_trig = '0;
    endtask

    // result is due two edges later through the two-stage pipeline
    task automatic compare_currents(input word_t rate_ia, input word_t rate_ii,
                                    input word_t exp_ia, input word_t exp_ii);
        i_rate_ia = rate_ia;
        i_rate_ii = rate_ii;
        step_cycle();
        // the sample sits on the inputs for one edge only
        i_rate_ia = ~rate_ia;
        i_rate_ii = ~rate_ii;
        step_cycle();
        check_word(o_current_ia, exp_ia, CURRENT_MASK, "current ia");
        check_word(o_current_ii, exp_ii, CURRENT_MASK, "current ii");
    endtask

    task automatic spike_burst(input word_t cycles);
        int i;
        for (i = 0; i < int'(cycles); i++)
        begin
            rnd_state  = xorshift32(rnd_state);
            i_spike_ia = rnd_state[0];
            i_spike_ii = rnd_state[9];
            tally_ia   = tally_ia + word_t'(rnd_state[0]);
            tally_ii   = tally_ii + word_t'(rnd_state[9]);
            step_cycle();
        end
        i_spike_ia = 1'b0;
        i_spike_ii = 1'b0;
        // last pulse was counted on the edge just passed
        check_word(o_spike_count_ia, tally_ia, ALL_BITS, "spike count ia");
        check_word(o_spike_count_ii, tally_ii, ALL_BITS, "spike count ii");
    endtask

    // anchor on one pulse and measure each following period
    task automatic tick_periods(input word_t count, input word_t period);
        word_t tag_start;
        int    gap;
        int    i;
        while (o_tick !== 1'b1)
            step_cycle();
        tag_start = o_time_tag;
        for (i = 1; i <= int'(count); i++)
        begin
            gap = 0;
            do
            begin
                step_cycle();
                gap++;
            end
            while (o_tick !== 1'b1);
            check_word(word_t'(gap), period, ALL_BITS, "tick period");
            check_word(o_time_tag, tag_start + word_t'(i), ALL_BITS, "time tag");
        end
    endtask

    task automatic fifo_flag_check(input word_t stim, input word_t expected);
        i_fifo_almost_full  = stim[0];
        i_fifo_almost_empty = stim[1];
        // mid-cycle the register still holds the previous pair
        #CLK_HALF;
        check_flags(o_fifo_flags, flags_prev, "fifo flags before edge");
        step_cycle();
        check_flags(o_fifo_flags, fifo_flags_t'(expected[1:0]), "fifo flags");
        flags_prev = fifo_flags_t'(expected[1:0]);
    endtask

    // counts clear while the time tag only moves by ticks seen meanwhile
    task automatic sim_reset_check();
        word_t tag_before;
        word_t ticks_seen;
        tag_before  = o_time_tag;
        i_sim_reset = 1'b1;
        step_cycle();
        i_sim_reset = 1'b0;
        ticks_seen  = word_t'(o_tick);
        check_word(o_spike_count_ia, '0, ALL_BITS, "spike count ia after sim reset");
        check_word(o_spike_count_ii, '0, ALL_BITS, "spike count ii after sim reset");
        check_word(o_time_tag, tag_before + ticks_seen, ALL_BITS, "time tag after sim reset");
        tally_ia = '0;
        tally_ii = '0;
    endtask

    initial
    begin
        int    idx;
        int    total;
        word_t op;
        word_t a0;
        word_t a1;
        word_t a2;
        word_t a3;

        ep50trig            = 1'b0;
        reset_global        = 1'b1;
        i_sim_reset         = 1'b0;
        i_trig              = '0;
        i_wire_hi           = '0;
        i_wire_lo           = '0;
        i_rate_ia           = '0;
        i_rate_ii           = '0;
        i_spike_ia          = 1'b0;
        i_spike_ii          = 1'b0;
        i_fifo_almost_full  = 1'b0;
        i_fifo_almost_empty = 1'b0;

        for (idx = 0; idx < MAX_RECORDS * REC_WORDS; idx++)
            stim_mem[idx] = '0;
        $readmemh("verif/rack_stim.txt", stim_mem);

        // cycle budget from the records themselves
        total = 0;
        idx = 0;
        while (idx < MAX_RECORDS && stim_mem[idx*REC_WORDS] != OP_END)
        begin
            total += record_cycles(stim_mem[idx*REC_WORDS], stim_mem[idx*REC_WORDS+1],
                                   stim_mem[idx*REC_WORDS+2]);
            idx++;
        end
        if (idx == 0)
        begin
            $display("stimulus file verif/rack_stim.txt holds no records");
            $display("FAIL: see errors above");
            $fatal(1, "empty stimulus");
        end
        limit_cycles = 2 * total + RESET_CYCLES;

        repeat (RESET_CYCLES) @(posedge ep50trig);
        #DRIVE_DELAY;
        reset_global = 1'b0;

        idx = 0;
        while (idx < MAX_RECORDS && stim_mem[idx*REC_WORDS] != OP_END)
        begin
            cur_record = idx;
            op = stim_mem[idx*REC_WORDS];
            a0 = stim_mem[idx*REC_WORDS+1];
            a1 = stim_mem[idx*REC_WORDS+2];
            a2 = stim_mem[idx*REC_WORDS+3];
            a3 = stim_mem[idx*REC_WORDS+4];
            case (op)
                OP_TRIG:      load_trigger(a0, a1);
                OP_RATE:      compare_currents(a0, a1, a2, a3);
                OP_SPIKE:     spike_burst(a0);
                OP_TICK:      tick_periods(a0, a1);
                OP_FIFO:      fifo_flag_check(a0, a1);
                OP_SIM_RESET: sim_reset_check();
                default:
                begin
                    $display("record %0d has unknown opcode %h", idx, op);
                    $display("FAIL: see errors above");
                    $fatal(1, "bad stimulus record");
                end
            endcase
            idx++;
        end

        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/rack_stim.txt
// columns, all hex: opcode arg0 arg1 arg2 arg3
// 1 trig mask value | 2 rate ia ii exp_ia exp_ii | 3 spike cycles | 4 tick periods div | 5 fifo {ae,af} exp | 6 sim reset
// default divider right after reset
4 00000001 0000017D 00000000 00000000
// default offsets and gains
2 0000042E 00000096 00012BC0 00003200
2 000186E6 0000041A 00752FC0 0001F400
2 00000046 00000032 00000000 00000000
// rate below offset, channels independent
2 00000014 0000041A FFFFF100 0001F400
2 00000014 00000000 FFFFF100 FFFFE700
// fifo status combinations
5 00000001 00000001 00000000 00000000
5 00000002 00000002 00000000 00000000
5 00000003 00000003 00000000 00000000
5 00000000 00000000 00000000 00000000
// random spike bursts
3 00000028 00000000 00000000 00000000
3 00000019 00000000 00000000 00000000
// offset ia to 1000
1 00000008 000003E8 00000000 00000000
2 00000BB8 00000096 000257C0 00003200
// both gains to 3.0 in one strobe
1 00000402 00030000 00000000 00000000
2 00000BB8 00000096 0005DC00 00004B00
// unassigned bits leave everything alone
1 00008005 DEADBEEF 00000000 00000000
2 00000BB8 00000096 0005DC00 00004B00
// offset ii to 100
1 00000040 00000064 00000000 00000000
2 00000BB8 00000096 0005DC00 00002580
// small divider
1 00000080 00000005 00000000 00000000
4 00000004 00000005 00000000 00000000
3 0000001E 00000000 00000000 00000000
// sim reset keeps parameters and time tag
6 00000000 00000000 00000000 00000000
2 00000BB8 00000096 0005DC00 00002580
3 00000014 00000000 00000000 00000000
// another divider value
1 00000080 00000009 00000000 00000000
4 00000003 00000009 00000000 00000000
5 00000002 00000002 00000000 00000000
5 00000000 00000000 00000000 00000000
// end of records
0 00000000 00000000 00000000 00000000

//--- rack_core.f
rtl/rack_pkg.sv
rtl/param_decode.sv
rtl/afferent_current.sv
rtl/rack_monitor.sv
rtl/rack_core.sv
verif/tb_rack_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile and run the rack_core testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module tb_rack_core -f rack_core.f -o sim_rack_core

./obj_dir/sim_rack_core 2>&1 | tee sim.log

if grep -q "PASS: all tests" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
